//--- design/rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int xlen = 32;                  // data and address width
    localparam int regAddrWidth = 5;           // 32 integer registers

    typedef logic [xlen-1:0] word;
    typedef logic [regAddrWidth-1:0] regAddr;

    // base opcodes of the supported subset
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;   // addi, slti, shifts with immediate
    localparam logic [6:0] opReg    = 7'b0110011;   // register-register ops

    // ALU operation select
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSlt  = 4'd6,
        aluSltu = 4'd7,
        aluSra  = 4'd8,
        aluSrl  = 4'd9
    } aluOp;

    // immediate layout per instruction format
    typedef enum logic [2:0] {
        immI = 3'd0,                           // alu imm, loads, jalr
        immS = 3'd1,                           // stores
        immB = 3'd2,                           // branches, 13-bit offset
        immU = 3'd3,                           // lui, auipc
        immJ = 3'd4                            // jal, 21-bit offset
    } immFormat;

    // ALU operand A source
    typedef enum logic [1:0] {
        srcRs1  = 2'd0,
        srcPc   = 2'd1,                        // auipc
        srcZero = 2'd2                         // lui
    } srcASel;

    // register write-back source
    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2                      // link value for jal / jalr
    } resultSel;

endpackage

`default_nettype wire

//--- design/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
    parameter rvPkg::word resetPc = '0
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       pcTaken,           // branch taken or jump
    input  wire logic       jumpReg,           // jalr
    input  wire rvPkg::word immExt,
    input  wire rvPkg::word aluResult,         // rs1 + imm for jalr
    output rvPkg::word      pc,
    output rvPkg::word      pcPlus4
);

    rvPkg::word pcTarget;                      // pc-relative target
    rvPkg::word jumpTarget;
    rvPkg::word pcNext;

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + immExt;

    // jalr clears bit 0 of the computed address
    assign jumpTarget = jumpReg ? {aluResult[rvPkg::xlen-1:1], 1'b0} : pcTarget;

    assign pcNext = pcTaken ? jumpTarget : pcPlus4;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= resetPc;
        end else begin
            pc <= pcNext;                      // one instruction per edge
        end
    end

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic          clk,
    input  wire rvPkg::regAddr rs1,
    input  wire rvPkg::regAddr rs2,
    input  wire rvPkg::regAddr rd,
    input  wire logic          writeEnable,
    input  wire rvPkg::word    writeValue,
    output rvPkg::word         rs1Value,
    output rvPkg::word         rs2Value
);

    // x0 has no storage
    rvPkg::word regs [1:31];

    always_ff @(posedge clk) begin
        if (writeEnable && (rd != '0)) begin
            regs[rd] <= writeValue;            // writes to x0 dropped
        end
    end

    // asynchronous reads, x0 forced to zero
    assign rs1Value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- design/immExtend.sv
`timescale 1ns/1ps
`default_nettype none

module immExtend (
    input  wire rvPkg::word      instr,
    input  wire rvPkg::immFormat immSel,
    output rvPkg::word           immExt
);

    logic sign;

    assign sign = instr[31];                   // always the msb of the immediate

    always_comb begin
        case (immSel)
            rvPkg::immS: begin
                // split field, imm[11:5] and imm[4:0]
                immExt = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            rvPkg::immB: begin
                // imm[12|10:5] and imm[4:1|11], bit 0 implied
                immExt = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rvPkg::immU: begin
                immExt = {instr[31:12], 12'b0};   // upper 20 bits, no extension
            end
            rvPkg::immJ: begin
                // imm[20|10:1|11|19:12], bit 0 implied
                immExt = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                immExt = {{20{sign}}, instr[31:20]};  // I format
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  wire rvPkg::srcASel   srcSel,
    input  wire logic            useImm,
    input  wire rvPkg::aluOp     aluControl,
    input  wire rvPkg::resultSel resSel,
    input  wire rvPkg::word      rs1Value,
    input  wire rvPkg::word      rs2Value,
    input  wire rvPkg::word      immExt,
    input  wire rvPkg::word      pc,
    input  wire rvPkg::word      pcPlus4,
    input  wire rvPkg::word      readData,
    output rvPkg::word           aluResult,
    output rvPkg::word           result,        // register write-back value
    output logic                 zero,
    output logic                 lt,
    output logic                 ltu
);

    rvPkg::word srcA;
    rvPkg::word srcB;
    logic [4:0] shamt;

    // operand A mux
    always_comb begin
        case (srcSel)
            rvPkg::srcPc:   srcA = pc;         // auipc
            rvPkg::srcZero: srcA = '0;         // lui passes the imm through
            default:        srcA = rs1Value;
        endcase
    end

    assign srcB  = useImm ? immExt : rs2Value;
    assign shamt = srcB[4:0];                  // only low 5 bits shift

    // compare flags, valid for any alu op
    assign lt  = $signed(srcA) < $signed(srcB);
    assign ltu = srcA < srcB;

    always_comb begin
        case (aluControl)
            rvPkg::aluAdd:  aluResult = srcA + srcB;
            rvPkg::aluSub:  aluResult = srcA - srcB;
            rvPkg::aluAnd:  aluResult = srcA & srcB;
            rvPkg::aluOr:   aluResult = srcA | srcB;
            rvPkg::aluXor:  aluResult = srcA ^ srcB;
            rvPkg::aluSll:  aluResult = srcA << shamt;
            rvPkg::aluSlt:  aluResult = {{(rvPkg::xlen-1){1'b0}}, lt};
            rvPkg::aluSltu: aluResult = {{(rvPkg::xlen-1){1'b0}}, ltu};
            rvPkg::aluSra:  aluResult = $signed(srcA) >>> shamt;   // keeps sign
            rvPkg::aluSrl:  aluResult = srcA >> shamt;
            default:        aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);           // beq/bne after sub

    // write-back mux
    always_comb begin
        case (resSel)
            rvPkg::resMem:     result = readData;
            rvPkg::resPcPlus4: result = pcPlus4;   // link address
            default:           result = aluResult;
        endcase
    end

endmodule

`default_nettype wire

//--- design/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire rvPkg::word instr,
    input  wire logic       zero,              // alu result is zero
    input  wire logic       lt,                // signed a < b
    input  wire logic       ltu,               // unsigned a < b
    output rvPkg::aluOp     aluControl,
    output rvPkg::immFormat immSel,
    output rvPkg::srcASel   srcSel,
    output logic            useImm,            // operand B from immediate
    output rvPkg::resultSel resSel,
    output logic            regWrite,
    output logic            memWrite,
    output logic            pcTaken,           // load branch/jump target
    output logic            jumpReg            // jalr target from alu
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       isBranch;
    logic       isJump;
    logic       isAluOp;                       // opImm or opReg
    logic       isRegOp;
    logic       branchCond;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];               // sub / sra select

    // main decoder
    always_comb begin
        immSel   = rvPkg::immI;                // defaults give a bubble, no writes
        srcSel   = rvPkg::srcRs1;
        useImm   = 1'b0;
        resSel   = rvPkg::resAlu;
        regWrite = 1'b0;
        memWrite = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        jumpReg  = 1'b0;
        isAluOp  = 1'b0;
        isRegOp  = 1'b0;
        case (opcode)
            rvPkg::opReg: begin
                regWrite = 1'b1;
                isAluOp  = 1'b1;
                isRegOp  = 1'b1;
            end
            rvPkg::opImm: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                isAluOp  = 1'b1;
            end
            rvPkg::opLoad: begin
                regWrite = 1'b1;
                useImm   = 1'b1;               // rs1 + offset
                resSel   = rvPkg::resMem;
            end
            rvPkg::opStore: begin
                immSel   = rvPkg::immS;
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            rvPkg::opBranch: begin
                immSel   = rvPkg::immB;        // rs1 vs rs2 in alu, offset to pc adder
                isBranch = 1'b1;
            end
            rvPkg::opLui: begin
                immSel   = rvPkg::immU;
                srcSel   = rvPkg::srcZero;     // 0 + upper imm
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            rvPkg::opAuipc: begin
                immSel   = rvPkg::immU;
                srcSel   = rvPkg::srcPc;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            rvPkg::opJal: begin
                immSel   = rvPkg::immJ;
                resSel   = rvPkg::resPcPlus4;  // link
                regWrite = 1'b1;
                isJump   = 1'b1;
            end
            rvPkg::opJalr: begin
                useImm   = 1'b1;               // target = rs1 + imm
                resSel   = rvPkg::resPcPlus4;
                regWrite = 1'b1;
                isJump   = 1'b1;
                jumpReg  = 1'b1;
            end
            default: ;
        endcase
    end

    // alu operation decoder
    always_comb begin
        aluControl = rvPkg::aluAdd;            // addresses, lui, auipc
        if (isBranch) begin
            // bltu/bgeu compare unsigned, the rest use the subtract flags
            aluControl = (funct3[2:1] == 2'b11) ? rvPkg::aluSltu : rvPkg::aluSub;
        end else if (isAluOp) begin
            case (funct3)
                3'b000:  aluControl = (isRegOp && funct7b5) ? rvPkg::aluSub : rvPkg::aluAdd;
                3'b001:  aluControl = rvPkg::aluSll;
                3'b010:  aluControl = rvPkg::aluSlt;
                3'b011:  aluControl = rvPkg::aluSltu;
                3'b100:  aluControl = rvPkg::aluXor;
                3'b101:  aluControl = funct7b5 ? rvPkg::aluSra : rvPkg::aluSrl;   // srai too
                3'b110:  aluControl = rvPkg::aluOr;
                default: aluControl = rvPkg::aluAnd;
            endcase
        end
    end

    // branch condition from funct3
    always_comb begin
        case (funct3)
            3'b000:  branchCond = zero;        // beq
            3'b001:  branchCond = ~zero;       // bne
            3'b100:  branchCond = lt;          // blt
            3'b101:  branchCond = ~lt;         // bge
            3'b110:  branchCond = ltu;         // bltu
            3'b111:  branchCond = ~ltu;        // bgeu
            default: branchCond = 1'b0;        // reserved encodings fall through
        endcase
    end

    assign pcTaken = (isBranch & branchCond) | isJump;

endmodule

`default_nettype wire

//--- design/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
    parameter rvPkg::word resetPc = '0         // first fetch address after reset
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire rvPkg::word instr,             // fetched word at pc
    input  wire rvPkg::word readData,          // data memory word at dataAddr
    output rvPkg::word      pc,
    output rvPkg::word      dataAddr,
    output rvPkg::word      writeData,
    output logic            memWrite
);

    rvPkg::aluOp     aluControl;
    rvPkg::immFormat immSel;
    rvPkg::srcASel   srcSel;
    rvPkg::resultSel resSel;
    logic            useImm;
    logic            regWrite;
    logic            pcTaken;
    logic            jumpReg;
    logic            zero, lt, ltu;            // compare flags back to control

    rvPkg::word pcPlus4;
    rvPkg::word immExt;
    rvPkg::word rs1Value, rs2Value;
    rvPkg::word aluResult;
    rvPkg::word result;                        // write-back value

    controlUnit controlUnit_i (
        .instr(instr), .zero(zero), .lt(lt), .ltu(ltu),
        .aluControl(aluControl), .immSel(immSel), .srcSel(srcSel), .useImm(useImm),
        .resSel(resSel), .regWrite(regWrite), .memWrite(memWrite),
        .pcTaken(pcTaken), .jumpReg(jumpReg)
    );

    pcUnit #(.resetPc(resetPc)) pcUnit_i (
        .clk(clk), .reset(reset), .pcTaken(pcTaken), .jumpReg(jumpReg),
        .immExt(immExt), .aluResult(aluResult), .pc(pc), .pcPlus4(pcPlus4)
    );

    regFile regFile_i (
        .clk(clk),
        .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),   // fixed field slots
        .writeEnable(regWrite), .writeValue(result),
        .rs1Value(rs1Value), .rs2Value(rs2Value)
    );

    immExtend immExtend_i (.instr(instr), .immSel(immSel), .immExt(immExt));

    executeUnit executeUnit_i (
        .srcSel(srcSel), .useImm(useImm), .aluControl(aluControl), .resSel(resSel),
        .rs1Value(rs1Value), .rs2Value(rs2Value), .immExt(immExt),
        .pc(pc), .pcPlus4(pcPlus4), .readData(readData),
        .aluResult(aluResult), .result(result), .zero(zero), .lt(lt), .ltu(ltu)
    );

    assign dataAddr  = aluResult;              // load/store effective address
    assign writeData = rs2Value;               // store data straight from rs2

endmodule

`default_nettype wire

//--- include/rvEncode.svh
`ifndef RV_ENCODE_SVH
`define RV_ENCODE_SVH

localparam int programLength = 64;             // instruction memory words
localparam int dataDepth = 64;                 // data memory words
localparam logic [31:0] seed = 32'h21ac;

// raw formats
function automatic rvPkg::word encR(input logic [6:0] funct7, input rvPkg::regAddr rs2,
                                    input rvPkg::regAddr rs1, input logic [2:0] funct3,
                                    input rvPkg::regAddr rd);
    return {funct7, rs2, rs1, funct3, rd, rvPkg::opReg};
endfunction

function automatic rvPkg::word encI(input logic [11:0] imm, input rvPkg::regAddr rs1,
                                    input logic [2:0] funct3, input rvPkg::regAddr rd,
                                    input logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
endfunction

function automatic rvPkg::word encS(input logic [11:0] imm, input rvPkg::regAddr rs2,
                                    input rvPkg::regAddr rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore};   // sw only
endfunction

function automatic rvPkg::word encB(input logic [12:0] off, input rvPkg::regAddr rs2,
                                    input rvPkg::regAddr rs1, input logic [2:0] funct3);
    return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], rvPkg::opBranch};
endfunction

function automatic rvPkg::word encU(input logic [19:0] imm, input rvPkg::regAddr rd,
                                    input logic [6:0] opcode);
    return {imm, rd, opcode};
endfunction

function automatic rvPkg::word encJ(input logic [20:0] off, input rvPkg::regAddr rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rvPkg::opJal};
endfunction

// common instructions
function automatic rvPkg::word insNop();
    return encI(12'd0, 5'd0, 3'b000, 5'd0, rvPkg::opImm);    // addi x0, x0, 0
endfunction

function automatic rvPkg::word insAddi(input rvPkg::regAddr rd, input rvPkg::regAddr rs1,
                                       input logic [11:0] imm);
    return encI(imm, rs1, 3'b000, rd, rvPkg::opImm);
endfunction

function automatic rvPkg::word insLw(input rvPkg::regAddr rd, input rvPkg::regAddr rs1,
                                     input logic [11:0] imm);
    return encI(imm, rs1, 3'b010, rd, rvPkg::opLoad);
endfunction

function automatic rvPkg::word insJalr(input rvPkg::regAddr rd, input rvPkg::regAddr rs1,
                                       input logic [11:0] imm);
    return encI(imm, rs1, 3'b000, rd, rvPkg::opJalr);
endfunction

// lui part of a constant, rounded so a following addi adds the low part back
function automatic logic [19:0] hiPart(input rvPkg::word value);
    rvPkg::word rounded;
    rounded = value + 32'h800;
    return rounded[31:12];
endfunction

function automatic logic [11:0] loPart(input rvPkg::word value);
    return value[11:0];                        // sign-extended by addi
endfunction

`endif

//--- test/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb;

    `include "rvEncode.svh"

    localparam int halfPeriod = 2;
    localparam int period = 2 * halfPeriod;
    localparam int resetCycles = 3;
    localparam int imemBits = $clog2(programLength);
    localparam int dataBits = $clog2(dataDepth);
    // alu 43, upper 5, load/store 6, branch 41, jump 9, mid reset 10, plus every reset hold
    localparam int cycleBudget = 43 + 5 + 6 + 41 + 9 + 10 + 7 * resetCycles;
    localparam int watchdogNs = (cycleBudget + 50) * period;

    logic       clk;
    logic       reset;
    rvPkg::word instr;
    rvPkg::word readData;
    rvPkg::word pc;
    rvPkg::word dataAddr;
    rvPkg::word writeData;
    logic       memWrite;

    rvPkg::word imem [programLength];
    rvPkg::word dmem [dataDepth];
    rvPkg::word storeAddr [$];                 // every store seen on the data port
    rvPkg::word storeData [$];
    rvPkg::word pcTrace [$];                   // pc of each retired instruction
    int         resetStores = 0;
    int         emitAt;                        // next free instruction word

    rvCore #(.resetPc(32'd0)) rvCore_i (
        .clk(clk), .reset(reset), .instr(instr), .readData(readData),
        .pc(pc), .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite)
    );

    always #halfPeriod clk = ~clk;

    // combinational fetch and load, word addressed
    assign instr    = imem[pc[imemBits+1:2]];
    assign readData = dmem[dataAddr[dataBits+1:2]];

    always @(posedge clk) begin
        if (!reset) begin
            pcTrace.push_back(pc);
        end
        if (memWrite) begin
            dmem[dataAddr[dataBits+1:2]] <= writeData;
            storeAddr.push_back(dataAddr);
            storeData.push_back(writeData);
            if (reset) begin
                resetStores = resetStores + 1;   // must stay zero
            end
        end
    end

    initial begin
        #(watchdogNs);
        $display("timeout: the tests ran past their cycle budget");
        $display("Simulation FAILED");
        $fatal(1);
    end

    task automatic checkWord(input string name, input rvPkg::word got,
                             input rvPkg::word expected);
        if (got !== expected) begin
            $display("MISMATCH at %0d ns: %s got 0x%08h expected 0x%08h",
                     $time, name, got, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic checkPc(input string where, input rvPkg::word got,
                           input rvPkg::word expected);
        if (got !== expected) begin
            $display("MISMATCH at %0d ns: pc (%s) got 0x%08h expected 0x%08h",
                     $time, where, got, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // ISA result of an op-imm / op register instruction
    function automatic rvPkg::word aluModel(input logic [2:0] funct3, input logic alt,
                                            input rvPkg::word a, input rvPkg::word b);
        rvPkg::word value;
        case (funct3)
            3'd0:    value = alt ? a - b : a + b;
            3'd1:    value = a << b[4:0];
            3'd2:    value = {31'b0, $signed(a) < $signed(b)};
            3'd3:    value = {31'b0, a < b};
            3'd4:    value = a ^ b;
            3'd5:    value = alt ? rvPkg::word'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    value = a | b;
            default: value = a & b;
        endcase
        return value;
    endfunction

    function automatic logic branchTaken(input logic [2:0] funct3, input rvPkg::word x,
                                         input rvPkg::word y);
        logic taken;
        case (funct3)
            3'd0:    taken = (x == y);
            3'd1:    taken = (x != y);
            3'd4:    taken = $signed(x) < $signed(y);
            3'd5:    taken = $signed(x) >= $signed(y);
            3'd6:    taken = x < y;
            3'd7:    taken = x >= y;
            default: taken = 1'b0;
        endcase
        return taken;
    endfunction

    task automatic placeWord(input int addrWord, input rvPkg::word ins);
        imem[addrWord[imemBits-1:0]] = ins;
    endtask

    task automatic emit(input rvPkg::word ins);
        placeWord(emitAt, ins);
        emitAt = emitAt + 1;
    endtask

    task automatic loadConst(input rvPkg::regAddr rd, input rvPkg::word value);
        emit(encU(hiPart(value), rd, rvPkg::opLui));
        emit(insAddi(rd, rd, loPart(value)));
    endtask

    task automatic beginTest();
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < programLength; i++) begin
            placeWord(i, insNop());
        end
        emitAt = 1;                            // word 0 stays a nop for reset
    endtask

    task automatic releaseReset();
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
        storeAddr.delete();
        storeData.delete();
        pcTrace.delete();
    endtask

    task automatic runCycles(input int count);
        repeat (count) @(posedge clk);
        #1;
    endtask

    task automatic aluTest();
        rvPkg::word  a;
        rvPkg::word  b;
        rvPkg::word  immValue;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        logic [2:0]  regF3 [10];
        logic        regAlt [10];
        rvPkg::word  expected [$];
        regF3  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        regAlt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};   // sub, sra
        beginTest();
        a = $urandom | 32'h8000_0000;          // negative, sra differs from srl
        b = ($urandom & 32'h7fff_ffff) | 32'd1;   // positive, odd shift amount
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            emit(encR({1'b0, regAlt[k], 5'b0}, 5'd2, 5'd1, regF3[k], 5'd3));
            emit(encS(12'(4 * k), 5'd3, 5'd0));
            expected.push_back(aluModel(regF3[k], regAlt[k], a, b));
        end
        for (int j = 0; j < 9; j++) begin
            f3 = (j == 8) ? 3'd5 : 3'(j);      // last one is srai
            alt = (j == 8);
            imm = 12'($urandom);
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {1'b0, alt, 5'b0, imm[4:1], 1'b1};   // funct7 over nonzero shamt
            end
            immValue = {{20{imm[11]}}, imm};
            emit(encI(imm, 5'd1, f3, 5'd3, rvPkg::opImm));
            emit(encS(12'(40 + 4 * j), 5'd3, 5'd0));
            expected.push_back(aluModel(f3, alt, a, immValue));
        end
        releaseReset();
        runCycles(emitAt);
        checkWord("alu store count", 32'(storeData.size()), 32'(expected.size()));
        for (int k = 0; k < expected.size(); k++) begin
            checkWord($sformatf("writeData[%0d]", k), storeData[k], expected[k]);
            checkWord($sformatf("dataAddr[%0d]", k), storeAddr[k], 32'(4 * k));
        end
    endtask

    task automatic upperTest();
        logic [19:0] upper1;
        logic [19:0] upper2;
        beginTest();
        upper1 = 20'($urandom);
        upper2 = 20'($urandom);
        emit(encU(upper1, 5'd4, rvPkg::opLui));
        emit(encS(12'd0, 5'd4, 5'd0));
        emit(encU(upper2, 5'd5, rvPkg::opAuipc));    // sits at pc 12
        emit(encS(12'd4, 5'd5, 5'd0));
        releaseReset();
        runCycles(emitAt);
        checkWord("upper store count", 32'(storeData.size()), 32'd2);
        checkWord("lui writeData", storeData[0], {upper1, 12'b0});
        checkWord("auipc writeData", storeData[1], {upper2, 12'b0} + 32'd12);
    endtask

    task automatic loadStoreTest();
        rvPkg::word value;
        beginTest();
        value = $urandom;
        loadConst(5'd6, value);
        emit(encS(12'd16, 5'd6, 5'd0));
        emit(insLw(5'd7, 5'd0, 12'd16));
        emit(encS(12'd20, 5'd7, 5'd0));        // reload goes out again
        releaseReset();
        runCycles(emitAt);
        checkWord("load store count", 32'(storeData.size()), 32'd2);
        checkWord("sw writeData", storeData[0], value);
        checkWord("lw round trip writeData", storeData[1], value);
        checkWord("second sw dataAddr", storeAddr[1], 32'd20);
    endtask

    task automatic branchTest();
        rvPkg::word     a;
        rvPkg::word     b;
        rvPkg::word     x;
        rvPkg::word     y;
        rvPkg::word     branchPc;
        rvPkg::regAddr  rs1;
        rvPkg::regAddr  rs2;
        logic [2:0]     kinds [6];
        rvPkg::word     expectPcs [$];
        kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        beginTest();
        a = $urandom | 32'h8000_0000;          // negative signed, large unsigned
        b = $urandom & 32'h7fff_ffff;
        loadConst(5'd8, a);
        loadConst(5'd9, b);
        for (int i = 0; i < 5; i++) begin
            expectPcs.push_back(32'(4 * i));
        end
        branchPc = 32'd20;
        for (int k = 0; k < $size(kinds); k++) begin
            // (a,b), (b,a), (a,a)
            for (int c = 0; c < 3; c++) begin
                rs1 = (c == 1) ? 5'd9 : 5'd8;
                rs2 = (c == 0) ? 5'd9 : 5'd8;
                x = (c == 1) ? b : a;
                y = (c == 0) ? b : a;
                emit(encB(13'd8, rs2, rs1, kinds[k]));
                emitAt = emitAt + 1;           // nop slot, skipped when taken
                expectPcs.push_back(branchPc);
                if (!branchTaken(kinds[k], x, y)) begin
                    expectPcs.push_back(branchPc + 32'd4);
                end
                branchPc = branchPc + 32'd8;
            end
        end
        releaseReset();
        runCycles(expectPcs.size());
        checkWord("branch trace length", 32'(pcTrace.size()), 32'(expectPcs.size()));
        for (int i = 0; i < expectPcs.size(); i++) begin
            checkPc($sformatf("branch step %0d", i), pcTrace[i], expectPcs[i]);
        end
    endtask

    task automatic jumpTest();
        rvPkg::word jalrTarget;
        rvPkg::word expectPcs [9];
        beginTest();
        placeWord(1, encJ(21'd12, 5'd10));             // pc 4 to 16
        placeWord(2, encS(12'd60, 5'd10, 5'd0));       // skipped
        placeWord(4, encS(12'd0, 5'd10, 5'd0));
        placeWord(5, insAddi(5'd11, 5'd0, 12'd37));
        placeWord(6, insJalr(5'd12, 5'd11, 12'd4));    // odd sum at pc 24
        placeWord(7, encS(12'd60, 5'd12, 5'd0));       // skipped
        placeWord(10, encS(12'd4, 5'd12, 5'd0));
        placeWord(11, encJ(21'd8, 5'd0));              // link into x0
        placeWord(12, encS(12'd60, 5'd12, 5'd0));      // skipped
        placeWord(13, insAddi(5'd0, 5'd0, 12'd5));
        placeWord(14, encS(12'd8, 5'd0, 5'd0));
        jalrTarget = (32'd37 + 32'd4) & ~32'd1;
        expectPcs = '{32'd0, 32'd4, 32'd4 + 32'd12, 32'd20, 32'd24, jalrTarget,
                      jalrTarget + 32'd4, jalrTarget + 32'd12, jalrTarget + 32'd16};
        releaseReset();
        runCycles($size(expectPcs));
        for (int i = 0; i < $size(expectPcs); i++) begin
            checkPc($sformatf("jump step %0d", i), pcTrace[i], expectPcs[i]);
        end
        checkWord("jump store count", 32'(storeData.size()), 32'd3);
        checkWord("jal link writeData", storeData[0], 32'd4 + 32'd4);
        checkWord("jalr link writeData", storeData[1], 32'd24 + 32'd4);
        checkWord("x0 writeData", storeData[2], 32'd0);
        checkWord("x0 store dataAddr", storeAddr[2], 32'd8);
    endtask

    task automatic resetTest();
        rvPkg::word value;
        beginTest();
        value = {21'b0, 11'($urandom)};        // positive, fits addi
        emit(insAddi(5'd13, 5'd0, value[11:0]));
        emit(encS(12'd0, 5'd13, 5'd0));
        emit(encS(12'd4, 5'd13, 5'd0));        // pc 12, cut off by reset
        emit(encS(12'd8, 5'd13, 5'd0));
        releaseReset();
        runCycles(3);
        checkPc("before mid reset", pc, 32'd12);
        reset = 1'b1;
        #1;
        checkPc("mid reset, async", pc, 32'd0);
        repeat (resetCycles) @(posedge clk);
        #1;
        checkPc("end of mid reset", pc, 32'd0);
        reset = 1'b0;
        runCycles(4);                          // replay from 0 up to pc 12
        checkPc("after replay", pc, 32'd16);
        checkWord("reset store count", 32'(storeData.size()), 32'd3);
        checkWord("first dataAddr", storeAddr[0], 32'd0);
        checkWord("replay dataAddr", storeAddr[1], 32'd0);
        checkWord("replay second dataAddr", storeAddr[2], 32'd4);
        for (int i = 0; i < 3; i++) begin
            checkWord($sformatf("reset writeData[%0d]", i), storeData[i], value);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;                          // nop at word 0 while held
        emitAt = 1;
        for (int i = 0; i < programLength; i++) begin
            placeWord(i, insNop());
        end
        void'($urandom(seed));
        aluTest();
        upperTest();
        loadStoreTest();
        branchTest();
        jumpTest();
        resetTest();
        checkWord("stores during reset", 32'(resetStores), 32'd0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
design/rvPkg.sv
design/pcUnit.sv
design/regFile.sv
design/immExtend.sv
design/executeUnit.sv
design/controlUnit.sv
design/rvCore.sv
test/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module coreTb \
    -f files.f \
    -o coreSim

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/coreSim
